/* ttl_pkg.sv */
package ttl_pkg;

    //////////////////////////////////////////////////
    // data path sizes
    //////////////////////////////////////////////////

    localparam int DATA_W = 8;   // one byte per transfer
    localparam int ADDR_W = 4;   // line buffer address, one 161 counter
    localparam int DEPTH  = 16;  // 2**ADDR_W entries
    localparam int CNT_W  = 5;   // occupancy 0..DEPTH

    //////////////////////////////////////////////////
    // gate stage opcodes
    //////////////////////////////////////////////////

    // each code picks one quad-gate chip
    // 6 and 7 are unused and give zero
    typedef enum logic [2:0] {
        op_and  = 3'd0,  // 7408
        op_or   = 3'd1,  // 7432
        op_xor  = 3'd2,  // 7486
        op_nand = 3'd3,  // 7400
        op_nor  = 3'd4,  // 7402
        op_inv  = 3'd5   // 7404, operand a only
    } alu_op_t;

    //////////////////////////////////////////////////
    // serializer states
    //////////////////////////////////////////////////

    typedef enum logic {
        ser_idle  = 1'b0,  // waiting for a byte
        ser_shift = 1'b1   // bits going out
    } ser_state_t;

endpackage

/* bin_counter.sv */
`timescale 1ns/1ps

// 161 style counter, async clear
module bin_counter (
    input  logic                       clk,
    input  logic                       cl_b,  // clears q
    input  logic                       ld_b,  // sync parallel load
    input  logic                       cep,   // count enable, parallel
    input  logic                       cet,   // count enable, trickle
    input  logic [ttl_pkg::ADDR_W-1:0] d,
    output logic [ttl_pkg::ADDR_W-1:0] q,
    output logic                       ca     // ripple carry out
);

    // carry when terminal count and cet, as on the chip
    assign ca = &{q, cet};

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            q <= '0;
        end else if (!ld_b) begin
            q <= d;                     // load wins over count
        end else if (cep && cet) begin
            q <= q + 1'b1;              // wraps 15 -> 0
        end
    end

endmodule

/* line_ram.sv */
`timescale 1ns/1ps

// small static RAM, read path is pure logic
module line_ram (
    input  logic                       clk,
    input  logic                       we,   // write strobe, active high
    input  logic [ttl_pkg::ADDR_W-1:0] wa,   // write address
    input  logic [ttl_pkg::ADDR_W-1:0] ra,   // read address
    input  logic [ttl_pkg::DATA_W-1:0] wd,
    output logic [ttl_pkg::DATA_W-1:0] rd
);
    import ttl_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];  // no clear

    // write on the rising edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
    end

    assign rd = mem[ra];  // async read

endmodule

/* gate_alu.sv */
`timescale 1ns/1ps

module gate_alu (
    input  logic                       clk,
    input  logic                       cl_b,      // async clear, active low
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [ttl_pkg::DATA_W-1:0] in_a,
    input  logic [ttl_pkg::DATA_W-1:0] in_b,
    input  ttl_pkg::alu_op_t           in_op,
    output logic                       res_valid,
    input  logic                       res_ready,
    output logic [ttl_pkg::DATA_W-1:0] res_data
);
    import ttl_pkg::*;

    logic [DATA_W-1:0] gate_out;  // combinational gate result
    logic              in_fire;   // input handshake
    logic              res_fire;  // result leaves the register

    //////////////////////////////////////////////////
    // gate array
    //////////////////////////////////////////////////

    // every bit position is one gate of the chip
    always_comb begin
        case (in_op)
            op_and:  gate_out = in_a & in_b;
            op_or:   gate_out = in_a | in_b;
            op_xor:  gate_out = in_a ^ in_b;
            op_nand: gate_out = ~(in_a & in_b);
            op_nor:  gate_out = ~(in_a | in_b);
            op_inv:  gate_out = ~in_a;          // b not wired
            default: gate_out = '0;             // unused codes
        endcase
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    assign res_fire = res_valid & res_ready;
    assign in_ready = ~res_valid | res_ready;  // empty or emptying now
    assign in_fire  = in_valid & in_ready;

    // valid flag, cleared by reset
    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            res_valid <= 1'b0;
        end else if (in_fire) begin
            res_valid <= 1'b1;                  // new result this edge
        end else if (res_fire) begin
            res_valid <= 1'b0;                  // drained, nothing behind
        end
    end

    // payload, like a 74273 with clock enable
    always_ff @(posedge clk) begin
        if (in_fire) begin
            res_data <= gate_out;
        end
    end

endmodule

/* line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
    input  logic                       clk,
    input  logic                       cl_b,
    input  logic                       wr_valid,
    output logic                       wr_ready,
    input  logic [ttl_pkg::DATA_W-1:0] wr_data,
    output logic                       rd_valid,
    input  logic                       rd_ready,
    output logic [ttl_pkg::DATA_W-1:0] rd_data
);
    import ttl_pkg::*;

    logic              wr_fire;       // byte written this edge
    logic              rd_fire;       // byte taken this edge
    logic [ADDR_W-1:0] wr_addr;       // write pointer counter
    logic [ADDR_W-1:0] rd_addr;       // read pointer counter
    logic              wr_ca;         // write pointer terminal count
    logic              rd_ca;         // read pointer terminal count
    logic              wr_wrap;       // flips each pass over the RAM
    logic              rd_wrap;
    logic              ptr_full;      // pointers say full
    logic [CNT_W-1:0]  occ;           // entries held

    assign wr_fire = wr_valid & wr_ready;
    assign rd_fire = rd_valid & rd_ready;

    //////////////////////////////////////////////////
    // pointers, two 161 counters
    //////////////////////////////////////////////////

    // cet carries the handshake so ca marks the wrap
    bin_counter wr_ptr (
        .clk  (clk),
        .cl_b (cl_b),
        .ld_b (cl_b),                 // load zero only while in reset
        .cep  (1'b1),
        .cet  (wr_fire),
        .d    ('0),
        .q    (wr_addr),
        .ca   (wr_ca)
    );

    bin_counter rd_ptr (
        .clk  (clk),
        .cl_b (cl_b),
        .ld_b (cl_b),
        .cep  (1'b1),
        .cet  (rd_fire),
        .d    ('0),
        .q    (rd_addr),
        .ca   (rd_ca)
    );

    // wrap flags, toggled by the ripple carry
    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            wr_wrap <= 1'b0;
            rd_wrap <= 1'b0;
        end else begin
            if (wr_ca) wr_wrap <= ~wr_wrap;
            if (rd_ca) rd_wrap <= ~rd_wrap;
        end
    end

    assign ptr_full = (wr_addr == rd_addr) & (wr_wrap != rd_wrap);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    line_ram ram (
        .clk (clk),
        .we  (wr_fire),
        .wa  (wr_addr),
        .ra  (rd_addr),
        .wd  (wr_data),
        .rd  (rd_data)                // head byte, no read latency
    );

    //////////////////////////////////////////////////
    // occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            occ <= '0;
        end else begin
            case ({wr_fire, rd_fire})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;  // both or neither
            endcase
        end
    end

    // full from the count, cross checked by the pointers
    assign wr_ready = (occ < CNT_W'(DEPTH)) & ~ptr_full;
    assign rd_valid = (occ != '0);

endmodule

/* shift_serializer.sv */
`timescale 1ns/1ps

module shift_serializer (
    input  logic                       clk,
    input  logic                       cl_b,
    input  logic                       byte_valid,
    output logic                       byte_ready,
    input  logic [ttl_pkg::DATA_W-1:0] byte_data,
    output logic                       ser_valid,
    input  logic                       ser_ready,
    output logic                       ser_data,    // msb of the shifter
    output logic                       ser_last     // eighth bit
);
    import ttl_pkg::*;

    ser_state_t        state;
    logic [DATA_W-1:0] sreg;       // 194 style shifter, 8 bits
    logic [2:0]        bit_cnt;    // bits already sent
    logic              byte_fire;
    logic              bit_fire;
    logic [1:0]        mode;       // 194 select lines

    assign ser_valid  = (state == ser_shift);
    assign ser_data   = sreg[DATA_W-1];
    assign ser_last   = ser_valid & (bit_cnt == 3'd7);
    assign bit_fire   = ser_valid & ser_ready;
    // refill as the last bit leaves, no bubble
    assign byte_ready = (state == ser_idle) | (bit_fire & ser_last);
    assign byte_fire  = byte_valid & byte_ready;

    //////////////////////////////////////////////////
    // shift register
    //////////////////////////////////////////////////

    // 11 parallel load, 10 shift toward msb, 00 hold
    always_comb begin
        if (byte_fire) begin
            mode = 2'b11;
        end else if (bit_fire) begin
            mode = 2'b10;
        end else begin
            mode = 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        case (mode)
            2'b11:   sreg <= byte_data;
            2'b10:   sreg <= {sreg[DATA_W-2:0], 1'b0};  // fill with zero
            default: sreg <= sreg;
        endcase
    end

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            state   <= ser_idle;
            bit_cnt <= '0;
        end else if (byte_fire) begin
            state   <= ser_shift;            // bit 7 out from this edge
            bit_cnt <= '0;
        end else if (bit_fire) begin
            bit_cnt <= bit_cnt + 1'b1;       // wraps to 0 after last
            if (ser_last) begin
                state <= ser_idle;           // nothing queued behind
            end
        end
    end

endmodule

/* logic_chain_top.sv */
`timescale 1ns/1ps

module logic_chain_top (
    input  logic                       clk,
    input  logic                       cl_b,
    // byte pair input
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [ttl_pkg::DATA_W-1:0] in_a,
    input  logic [ttl_pkg::DATA_W-1:0] in_b,
    input  ttl_pkg::alu_op_t           in_op,
    // serial output
    output logic                       ser_valid,
    input  logic                       ser_ready,
    output logic                       ser_data,
    output logic                       ser_last
);
    import ttl_pkg::*;

    logic              res_valid;   // gate stage to buffer
    logic              res_ready;
    logic [DATA_W-1:0] res_data;
    logic              buf_valid;   // buffer to serializer
    logic              buf_ready;
    logic [DATA_W-1:0] buf_data;

    //////////////////////////////////////////////////
    // producer, buffer, consumer
    //////////////////////////////////////////////////

    gate_alu alu (
        .clk       (clk),
        .cl_b      (cl_b),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_op     (in_op),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

    line_buffer buffer (
        .clk      (clk),
        .cl_b     (cl_b),
        .wr_valid (res_valid),
        .wr_ready (res_ready),
        .wr_data  (res_data),
        .rd_valid (buf_valid),
        .rd_ready (buf_ready),
        .rd_data  (buf_data)
    );

    shift_serializer serial (
        .clk        (clk),
        .cl_b       (cl_b),
        .byte_valid (buf_valid),
        .byte_ready (buf_ready),
        .byte_data  (buf_data),
        .ser_valid  (ser_valid),
        .ser_ready  (ser_ready),
        .ser_data   (ser_data),
        .ser_last   (ser_last)
    );

endmodule

/* logic_chain_checker.sv */
`timescale 1ns/1ps

module logic_chain_checker (
    input logic                      clk,
    input logic                      cl_b,
    input logic                      wr_valid,
    input logic                      wr_ready,
    input logic                      rd_valid,
    input logic                      rd_ready,
    input logic [ttl_pkg::CNT_W-1:0] occ      // buffer occupancy
);
    import ttl_pkg::*;

    logic             wr_fire;   // write handshake
    logic             rd_fire;   // read handshake
    logic [CNT_W-1:0] held;      // entries counted from the handshakes

    assign wr_fire = wr_valid & wr_ready;
    assign rd_fire = rd_valid & rd_ready;

    // own count of bytes inside the buffer
    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            held <= '0;
        end else begin
            held <= held + CNT_W'(wr_fire) - CNT_W'(rd_fire);
        end
    end

    //////////////////////////////////////////////////
    // line buffer rules
    //////////////////////////////////////////////////

    no_write_when_full: assert property (@(posedge clk) disable iff (!cl_b)
        (held == CNT_W'(DEPTH)) |-> !wr_fire)
        else $error("line buffer written while holding %0d entries", DEPTH);

    no_read_when_empty: assert property (@(posedge clk) disable iff (!cl_b)
        (held == '0) |-> !rd_fire)
        else $error("line buffer read while empty");

    // first edge after clear is released
    rd_low_after_reset: assert property (@(posedge clk)
        $rose(cl_b) |-> !rd_valid)
        else $error("rd_valid high right after reset");

    // DUT count follows the handshakes and stays in range
    occ_bounded: assert property (@(posedge clk) disable iff (!cl_b)
        (occ == held) && (occ <= CNT_W'(DEPTH)))
        else $error("occupancy %0d, handshakes give %0d", occ, held);

endmodule

bind line_buffer logic_chain_checker chk (
    .clk      (clk),
    .cl_b     (cl_b),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready),
    .occ      (occ)
);

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic por_b   // power-on reset, active low
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // low for 4 rising edges, released on a falling edge
    initial begin
        por_b = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        por_b = 1'b1;
    end

endmodule

/* logic_chain_tb.sv */
`timescale 1ns/1ps

module logic_chain_tb;
    import ttl_pkg::*;

    logic              clk;
    logic              por_b;
    logic              pulse_b;     // mid-stream clear pulse
    logic              cl_b;
    logic              in_valid;
    logic              in_ready;
    logic [DATA_W-1:0] in_a;
    logic [DATA_W-1:0] in_b;
    alu_op_t           in_op;
    logic              ser_valid;
    logic              ser_ready;
    logic              ser_data;
    logic              ser_last;

    logic [31:0]       lfsr;        // random source state
    logic [DATA_W-1:0] src_a[$];    // pairs not yet accepted
    logic [DATA_W-1:0] src_b[$];
    alu_op_t           src_op[$];
    logic [DATA_W-1:0] exp_q[$];    // reference bytes in arrival order
    logic [DATA_W-1:0] rx_byte;     // serial bits gathered so far
    logic              in_taken;    // drop in_valid at next falling edge
    int                rx_idx;
    int                accepted;
    int                err_count;

    assign cl_b = por_b & pulse_b;

    tb_clock clkgen (.clk(clk), .por_b(por_b));

    logic_chain_top dut (
        .clk       (clk),
        .cl_b      (cl_b),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_op     (in_op),
        .ser_valid (ser_valid),
        .ser_ready (ser_ready),
        .ser_data  (ser_data),
        .ser_last  (ser_last)
    );

    //////////////////////////////////////////////////
    // random source and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        end
        return n;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);       // one step per bit
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    // chip truth table indexed by {a, b}
    function automatic logic [3:0] gate_truth(input alu_op_t op);
        logic [3:0] tt;
        case (op)
            op_and:  tt = 4'b1000;
            op_or:   tt = 4'b1110;
            op_xor:  tt = 4'b0110;
            op_nand: tt = 4'b0111;
            op_nor:  tt = 4'b0001;
            op_inv:  tt = 4'b0011;        // follows a only
            default: tt = 4'b0000;        // unused codes
        endcase
        return tt;
    endfunction

    function automatic logic [DATA_W-1:0] expect_byte(input alu_op_t op,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        logic [3:0]        tt;
        logic [DATA_W-1:0] r;
        tt = gate_truth(op);
        for (int i = 0; i < DATA_W; i++) begin
            r[i] = tt[{a[i], b[i]}];
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic abort_run();
        err_count++;
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
            input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
            input logic [CNT_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // cycle driver and scoreboard
    //////////////////////////////////////////////////

    task automatic queue_pair(input alu_op_t op, input logic [DATA_W-1:0] a,
            input logic [DATA_W-1:0] b);
        src_op.push_back(op);
        src_a.push_back(a);
        src_b.push_back(b);
    endtask

    // drive on the falling edge and sample 1 ns later
    task automatic run_cycle(input logic offer, input logic take);
        @(negedge clk);
        if (in_taken) begin
            in_valid = 1'b0;
            in_taken = 1'b0;
        end
        if (!in_valid && offer && src_op.size() > 0) begin
            in_a     = src_a[0];
            in_b     = src_b[0];
            in_op    = src_op[0];
            in_valid = 1'b1;              // held until accepted
        end
        ser_ready = take;
        #1;
        if (!ser_valid) begin
            check_last("ser_last while idle", 1'b0, ser_last);
        end
        if (ser_valid && ser_ready) begin
            if (exp_q.size() == 0) begin
                $display("a serial bit came out at %0t ns with no byte expected", $time);
                abort_run();
            end
            check_last("ser_last", (rx_idx == 7), ser_last);
            rx_byte = {rx_byte[DATA_W-2:0], ser_data};   // msb first
            rx_idx++;
            if (rx_idx == DATA_W) begin
                check_byte("serial byte", exp_q[0], rx_byte);
                exp_q.delete(0);
                rx_idx = 0;
            end
        end
        if (in_valid && !in_taken && in_ready) begin
            exp_q.push_back(expect_byte(src_op[0], src_a[0], src_b[0]));
            src_op.delete(0);
            src_a.delete(0);
            src_b.delete(0);
            accepted++;
            in_taken = 1'b1;
        end
    endtask

    task automatic drain_chain(input logic throttle, input int limit);
        int         n;
        logic [7:0] r;
        n = 0;
        while (src_op.size() > 0 || exp_q.size() > 0 || (in_valid && !in_taken)) begin
            if (n >= limit) begin
                $display("timeout: chain did not drain within %0d cycles", limit);
                abort_run();
            end
            r = throttle ? rand_bits(2) : 8'h03;    // bit 1 offers and bit 0 takes
            run_cycle(r[1], r[0]);
            n++;
        end
    endtask

    task automatic wait_reset_release(input int limit);
        int n;
        n = 0;
        while (cl_b !== 1'b1) begin
            if (n >= limit) begin
                $display("timeout: reset was never released");
                abort_run();
            end
            @(negedge clk);
            n++;
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic each_opcode();
        alu_op_t op;
        op = op.first();
        for (int k = 0; k < op.num(); k++) begin
            queue_pair(op, 8'b1100_1010, 8'b1010_0110);  // all four bit pairs
            queue_pair(op, 8'h5a, 8'hf0);
            op = op.next();
        end
        drain_chain(1'b0, 300);
    endtask

    task automatic random_stream();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        for (int k = 0; k < 60; k++) begin
            a = rand_bits(8);
            b = rand_bits(8);
            c = rand_bits(3);                        // unused codes too
            queue_pair(alu_op_t'(c[2:0]), a, b);
        end
        drain_chain(1'b0, 800);
    endtask

    task automatic backpressure_fill();
        for (int k = 0; k < 20; k++) begin
            queue_pair(alu_op_t'(k % 6), rand_bits(8), rand_bits(8));
        end
        accepted = 0;
        repeat (30) run_cycle(1'b1, 1'b0);           // ser_ready held low
        check_count("bytes accepted", CNT_W'(18), CNT_W'(accepted));
        check_bit("in_ready when full", 1'b0, in_ready);
        repeat (10) run_cycle(1'b1, 1'b0);
        check_count("bytes accepted", CNT_W'(18), CNT_W'(accepted));
        drain_chain(1'b0, 400);
    endtask

    task automatic random_throttle();
        logic [7:0] c;
        for (int k = 0; k < 80; k++) begin
            c = rand_bits(3);
            queue_pair(alu_op_t'(c[2:0]), rand_bits(8), rand_bits(8));
        end
        drain_chain(1'b1, 5000);
    endtask

    task automatic reset_mid_stream();
        for (int k = 0; k < 10; k++) begin
            queue_pair(op_xor, rand_bits(8), rand_bits(8));
        end
        repeat (14) run_cycle(1'b1, 1'b1);           // one byte half shifted
        @(negedge clk);
        pulse_b  = 1'b0;
        in_valid = 1'b0;
        in_taken = 1'b0;
        src_op.delete();
        src_a.delete();
        src_b.delete();
        exp_q.delete();                              // in-flight bytes are gone
        rx_idx = 0;
        #1;
        check_bit("ser_valid in reset", 1'b0, ser_valid);
        repeat (2) @(negedge clk);
        pulse_b = 1'b1;
        #1;
        check_bit("ser_valid after reset", 1'b0, ser_valid);
        repeat (6) run_cycle(1'b0, 1'b1);            // any stale bit is an error
        queue_pair(op_nand, 8'h3c, 8'h96);
        drain_chain(1'b0, 100);
    endtask

    initial begin
        lfsr      = 32'h2350_bd3a;
        pulse_b   = 1'b1;
        in_valid  = 1'b0;
        in_a      = '0;
        in_b      = '0;
        in_op     = op_and;
        ser_ready = 1'b0;
        rx_byte   = '0;
        in_taken  = 1'b0;
        rx_idx    = 0;
        accepted  = 0;
        err_count = 0;
        wait_reset_release(20);
        each_opcode();
        random_stream();
        backpressure_fill();
        random_throttle();
        reset_mid_stream();
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* all.f */
ttl_pkg.sv
bin_counter.sv
line_ram.sv
gate_alu.sv
line_buffer.sv
shift_serializer.sv
logic_chain_top.sv
logic_chain_checker.sv
tb_clock.sv
logic_chain_tb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, verdict taken from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module logic_chain_tb -f all.f \
    -o logic_chain_sim && ./obj_dir/logic_chain_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
